/* rx_mac.f */
+incdir+.
rx_mac_pkg.sv
rx_word_if.sv
xgmii_rx_decode.sv
crc32_engine.sv
rx_frame_ctrl.sv
rx_axis_out.sv
rx_mac_top.sv
tb_rx_mac.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_rx_mac -f rx_mac.f \
    && ./obj_dir/Vtb_rx_mac > sim.log 2>&1 \
    || echo "build or simulation did not finish cleanly"
grep -q "SIMULATION PASSED" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_rx_mac.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rx_mac_macros.svh"

module tb_rx_mac;

    localparam int NUM_FRAMES = 40;
    localparam int MAX_CYCLES = NUM_FRAMES * 20 + 100;

    localparam int KIND_CLEAN = 0;
    localparam int KIND_FLIP  = 1;
    localparam int KIND_SFD   = 2;
    localparam int KIND_ERROR = 3;

    logic        i_clk;
    logic        i_reset;
    logic [63:0] i_xgmii_rxd;
    logic [7:0]  i_xgmii_rxc;
    wire  [63:0] o_tdata;
    wire  [7:0]  o_tkeep;
    wire         o_tvalid;
    wire         o_tlast;
    wire         o_tuser;
    wire  [15:0] o_good_frames;
    wire  [15:0] o_bad_frames;

    integer seed;
    int     cycle_count;

    // Byte lanes waiting to be packed into XGMII words
    logic [7:0] lane_data [$];
    logic       lane_ctrl [$];
    logic [7:0] payload [$];

    // Model state with the bytes of all received frames in order
    logic [7:0] exp_bytes [$];
    int         exp_len [$];
    logic       exp_bad [$];
    int         good_count;
    int         bad_count;
    int         rx_bytes;

    rx_mac_top rx_mac_top_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_xgmii_rxd   (i_xgmii_rxd),
        .i_xgmii_rxc   (i_xgmii_rxc),
        .o_tdata       (o_tdata),
        .o_tkeep       (o_tkeep),
        .o_tvalid      (o_tvalid),
        .o_tlast       (o_tlast),
        .o_tuser       (o_tuser),
        .o_good_frames (o_good_frames),
        .o_bad_frames  (o_bad_frames)
    );

    always #50 i_clk = ~i_clk;

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic push_lane(input logic [7:0] d, input logic c);
        lane_data.push_back(d);
        lane_ctrl.push_back(c);
    endtask

    task automatic push_idle_word();
        for (int i = 0; i < 8; i++)
            push_lane(`RX_IDLE_CHAR, 1'b1);
    endtask

    // Ethernet FCS over the payload in reflected form and inverted
    task automatic compute_fcs(output logic [31:0] fcs);
        logic [31:0] crc;
        crc = `RX_CRC_INIT;
        foreach (payload[i]) begin
            crc = crc ^ {24'h0, payload[i]};
            for (int b = 0; b < 8; b++) begin
                if (crc[0])
                    crc = (crc >> 1) ^ `RX_CRC_POLY;
                else
                    crc = crc >> 1;
            end
        end
        fcs = ~crc;
    endtask

    task automatic build_frame();
        logic [31:0] r;
        logic [31:0] fcs;
        logic [7:0]  sfd;
        int          len;
        int          kind;
        int          pos;
        int          gap;
        payload.delete();
        r = $random(seed);
        len = 16 + int'(r[7:0]) % 85;
        for (int i = 0; i < len; i++) begin
            r = $random(seed);
            payload.push_back(r[7:0]);
        end
        compute_fcs(fcs);

        // Roughly 5 in 8 frames stay clean
        r = $random(seed);
        if (r[3:0] < 4'd10)
            kind = KIND_CLEAN;
        else if (r[3:0] < 4'd12)
            kind = KIND_FLIP;
        else if (r[3:0] < 4'd14)
            kind = KIND_SFD;
        else
            kind = KIND_ERROR;
        pos = int'(r[31:16]) % len;
        sfd = `RX_SFD_BYTE;
        if (kind == KIND_FLIP)
            payload[pos] = payload[pos] ^ (r[11:4] | 8'h01);
        else if (kind == KIND_SFD)
            sfd = `RX_SFD_BYTE ^ (r[11:4] | 8'h01);
        else if (kind == KIND_ERROR)
            payload[pos] = `RX_ERROR_CHAR;

        // Start lane 4 puts four idles ahead of the start character
        r = $random(seed);
        if (r[0]) begin
            for (int i = 0; i < 4; i++)
                push_lane(`RX_IDLE_CHAR, 1'b1);
        end
        push_lane(`RX_START_CHAR, 1'b1);
        for (int i = 0; i < 6; i++)
            push_lane(`RX_PREAMBLE_BYTE, 1'b0);
        push_lane(sfd, 1'b0);
        for (int i = 0; i < len; i++)
            push_lane(payload[i], (kind == KIND_ERROR) && (i == pos));
        for (int i = 0; i < 4; i++)
            push_lane(fcs[i*8 +: 8], 1'b0);
        push_lane(`RX_TERM_CHAR, 1'b1);
        while (lane_data.size() % 8 != 0)
            push_lane(`RX_IDLE_CHAR, 1'b1);
        gap = 1 + int'(r[9:8]) % 3;
        for (int i = 0; i < gap; i++)
            push_idle_word();

        if (kind == KIND_SFD) begin
            bad_count++;
        end else begin
            foreach (payload[i])
                exp_bytes.push_back(payload[i]);
            exp_len.push_back(len);
            exp_bad.push_back(kind != KIND_CLEAN);
            if (kind == KIND_CLEAN)
                good_count++;
            else
                bad_count++;
        end
    endtask

    task automatic drive_stream();
        logic [63:0] d;
        logic [7:0]  c;
        while (lane_data.size() >= 8) begin
            for (int i = 0; i < 8; i++) begin
                d[i*8 +: 8] = lane_data.pop_front();
                c[i] = lane_ctrl.pop_front();
            end
            @(negedge i_clk);
            i_xgmii_rxd = d;
            i_xgmii_rxc = c;
        end
    endtask

    task automatic check_quiet_after_reset();
        repeat (4) begin
            @(negedge i_clk);
            assert (o_tvalid == 1'b0) else begin
                $display("ERR o_tvalid expected 0x0 got 0x%h", o_tvalid);
                stop_with_failure();
            end
            assert (o_good_frames == 16'h0) else begin
                $display("ERR o_good_frames expected 0x0000 got 0x%h", o_good_frames);
                stop_with_failure();
            end
            assert (o_bad_frames == 16'h0) else begin
                $display("ERR o_bad_frames expected 0x0000 got 0x%h", o_bad_frames);
                stop_with_failure();
            end
        end
    endtask

    // One output beat against the head of the model queues
    task automatic check_beat();
        logic [7:0] exp_b;
        logic [7:0] want_keep;
        logic [8:0] mask;
        logic       want_last;
        logic       want_user;
        int         remain;
        assert (exp_len.size() != 0) else begin
            $display("Output beat arrived while no frame was expected");
            stop_with_failure();
        end
        remain = exp_len[0] - rx_bytes;
        want_last = (remain <= 8);
        mask = (9'd1 << remain) - 9'd1;
        want_keep = want_last ? mask[7:0] : 8'hff;
        want_user = want_last && exp_bad[0];
        assert (o_tkeep == want_keep) else begin
            $display("ERR o_tkeep expected 0x%h got 0x%h", want_keep, o_tkeep);
            stop_with_failure();
        end
        assert (o_tlast == want_last) else begin
            $display("ERR o_tlast expected 0x%h got 0x%h", want_last, o_tlast);
            stop_with_failure();
        end
        assert (o_tuser == want_user) else begin
            $display("ERR o_tuser expected 0x%h got 0x%h", want_user, o_tuser);
            stop_with_failure();
        end
        for (int i = 0; i < 8; i++) begin
            if (want_keep[i]) begin
                exp_b = exp_bytes.pop_front();
                assert (o_tdata[i*8 +: 8] == exp_b) else begin
                    $display("ERR o_tdata lane %0d expected 0x%h got 0x%h",
                             i, exp_b, o_tdata[i*8 +: 8]);
                    stop_with_failure();
                end
                rx_bytes++;
            end else begin
                // Lanes outside keep read as zero
                assert (o_tdata[i*8 +: 8] == 8'h00) else begin
                    $display("ERR o_tdata lane %0d expected 0x00 got 0x%h",
                             i, o_tdata[i*8 +: 8]);
                    stop_with_failure();
                end
            end
        end
        if (want_last) begin
            void'(exp_len.pop_front());
            void'(exp_bad.pop_front());
            rx_bytes = 0;
        end
    endtask

    always @(negedge i_clk) begin
        if (!i_reset && o_tvalid)
            check_beat();
    end

    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with frames still outstanding", cycle_count);
            stop_with_failure();
        end
    end

    initial begin
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_xgmii_rxd = {8{`RX_IDLE_CHAR}};
        i_xgmii_rxc = 8'hff;
        seed        = 32'ha1b1;
        cycle_count = 0;
        good_count  = 0;
        bad_count   = 0;
        rx_bytes    = 0;
        repeat (3) @(negedge i_clk);
        i_reset = 1'b0;
        check_quiet_after_reset();

        for (int f = 0; f < NUM_FRAMES; f++) begin
            build_frame();
            drive_stream();
        end

        // Dropped frames show up only in the counters
        while (exp_len.size() != 0 ||
               int'(o_good_frames) + int'(o_bad_frames) != NUM_FRAMES)
            @(negedge i_clk);

        assert (o_good_frames == 16'(good_count)) else begin
            $display("ERR o_good_frames expected 0x%h got 0x%h", 16'(good_count), o_good_frames);
            stop_with_failure();
        end
        assert (o_bad_frames == 16'(bad_count)) else begin
            $display("ERR o_bad_frames expected 0x%h got 0x%h", 16'(bad_count), o_bad_frames);
            stop_with_failure();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* rx_mac_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_mac_top (
    input  wire         i_clk,
    input  wire         i_reset,
    input  wire  [63:0] i_xgmii_rxd,
    input  wire  [7:0]  i_xgmii_rxc,
    output wire  [63:0] o_tdata,
    output wire  [7:0]  o_tkeep,
    output wire         o_tvalid,
    output wire         o_tlast,
    output wire         o_tuser,
    output wire  [15:0] o_good_frames,
    output wire  [15:0] o_bad_frames
);

    logic        crc_clear;
    logic [63:0] crc_data;
    logic [7:0]  crc_byte_en;
    logic [31:0] crc_value;

    // Aligned frame words, and payload beats after FCS removal
    rx_word_if dec_word ();
    rx_word_if out_word ();

    xgmii_rx_decode xgmii_rx_decode_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_xgmii_rxd (i_xgmii_rxd),
        .i_xgmii_rxc (i_xgmii_rxc),
        .o_word      (dec_word.source)
    );

    rx_frame_ctrl rx_frame_ctrl_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_word        (dec_word.sink),
        .o_word        (out_word.source),
        .o_crc_clear   (crc_clear),
        .o_crc_data    (crc_data),
        .o_crc_byte_en (crc_byte_en),
        .i_crc         (crc_value)
    );

    crc32_engine crc32_engine_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_clear   (crc_clear),
        .i_data    (crc_data),
        .i_byte_en (crc_byte_en),
        .o_crc     (crc_value)
    );

    rx_axis_out rx_axis_out_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_word        (out_word.sink),
        .o_tdata       (o_tdata),
        .o_tkeep       (o_tkeep),
        .o_tvalid      (o_tvalid),
        .o_tlast       (o_tlast),
        .o_tuser       (o_tuser),
        .o_good_frames (o_good_frames),
        .o_bad_frames  (o_bad_frames)
    );

endmodule

`default_nettype wire

/* rx_axis_out.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_axis_out (
    input  wire         i_clk,
    input  wire         i_reset,
    rx_word_if.sink     i_word,
    output logic [63:0] o_tdata,
    output logic [7:0]  o_tkeep,
    output logic        o_tvalid,
    output logic        o_tlast,
    output logic        o_tuser,
    output logic [15:0] o_good_frames,
    output logic [15:0] o_bad_frames
);

    logic [63:0] masked_data;

    always_comb begin
        for (int i = 0; i < 8; i++)
            masked_data[i*8 +: 8] = i_word.keep[i] ? i_word.data[i*8 +: 8] : 8'h00;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_tvalid      <= 1'b0;
            o_tlast       <= 1'b0;
            o_tuser       <= 1'b0;
            o_good_frames <= 16'd0;
            o_bad_frames  <= 16'd0;
        end else begin
            o_tvalid <= i_word.valid;
            o_tlast  <= i_word.valid && i_word.eof;
            o_tuser  <= i_word.valid && i_word.eof && i_word.err;
            // Dropped frames arrive as eof without valid, counted bad
            if (i_word.eof && i_word.err)
                o_bad_frames <= o_bad_frames + 16'd1;
            else if (i_word.eof)
                o_good_frames <= o_good_frames + 16'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        o_tdata <= masked_data;
        o_tkeep <= i_word.keep;
    end

    a_keep_on_valid: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_tvalid |-> o_tkeep != 8'h00
    );

endmodule

`default_nettype wire

/* rx_frame_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rx_mac_macros.svh"

module rx_frame_ctrl
    import rx_mac_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_reset,
    rx_word_if.sink     i_word,
    rx_word_if.source   o_word,
    output logic        o_crc_clear,
    output logic [63:0] o_crc_data,
    output logic [7:0]  o_crc_byte_en,
    input  wire  [31:0] i_crc
);

    rx_state_t    state;

    logic [63:0]  hold_data;
    logic [7:0]   tail_keep;
    logic         tail_q;
    logic         first_q;
    logic         err_acc;
    logic [31:0]  fcs_q;

    logic         out_valid;
    logic         out_sof;
    logic         out_eof;
    logic         out_bad;
    logic [63:0]  out_data;
    logic [7:0]   out_keep;
    logic         sof_seen;

    logic         pre_ok;
    logic [3:0]   last_count;
    logic [6:0]   fcs_base;
    logic [127:0] last_pair;
    logic [31:0]  fcs_next;

    // Held sof word carries start char, six preamble bytes and SFD
    assign pre_ok = (hold_data[55:8] == {6{`RX_PREAMBLE_BYTE}}) &&
                    (hold_data[63:56] == `RX_SFD_BYTE);

    always_comb begin
        last_count = 4'd0;
        for (int i = 0; i < 8; i++)
            last_count = last_count + {3'b000, i_word.keep[i]};
    end

    // FCS is the last four bytes of held word plus eof word
    assign last_pair = {i_word.data, hold_data};
    assign fcs_base  = {last_count + 4'd4, 3'b000};
    assign fcs_next  = last_pair[fcs_base +: 32];

    // CRC sees payload only and runs one word behind the input
    assign o_crc_clear = (state == IDLE) && i_word.valid && i_word.sof;
    assign o_crc_data  = hold_data;

    always_comb begin
        o_crc_byte_en = 8'h00;
        if (state == DATA) begin
            if (tail_q)
                o_crc_byte_en = tail_keep;
            else if (i_word.valid && i_word.eof && !i_word.keep[4])
                o_crc_byte_en = {i_word.keep[3:0], 4'hf};
            else if (i_word.valid)
                o_crc_byte_en = 8'hff;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= IDLE;
            tail_q    <= 1'b0;
            first_q   <= 1'b0;
            out_valid <= 1'b0;
            out_sof   <= 1'b0;
            out_eof   <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            out_sof   <= 1'b0;
            out_eof   <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_word.valid && i_word.sof)
                        state <= PREAMBLE;
                end
                PREAMBLE: begin
                    if (i_word.valid) begin
                        if (pre_ok) begin
                            state   <= DATA;
                            first_q <= 1'b1;
                        end else if (i_word.eof) begin
                            out_eof <= 1'b1;
                            state   <= IDLE;
                        end else begin
                            state <= DROP;
                        end
                    end
                end
                DATA: begin
                    if (tail_q) begin
                        out_valid <= 1'b1;
                        out_eof   <= 1'b1;
                        tail_q    <= 1'b0;
                        state     <= IDLE;
                    end else if (i_word.valid) begin
                        out_valid <= 1'b1;
                        out_sof   <= first_q;
                        first_q   <= 1'b0;
                        // More than four bytes in the eof word leaves a tail beat
                        if (i_word.eof && i_word.keep[4]) begin
                            tail_q <= 1'b1;
                        end else if (i_word.eof) begin
                            out_eof <= 1'b1;
                            state   <= IDLE;
                        end
                    end
                end
                DROP: begin
                    if (i_word.valid && i_word.eof) begin
                        out_eof <= 1'b1;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        case (state)
            IDLE: begin
                hold_data <= i_word.data;
                err_acc   <= i_word.err;
            end
            PREAMBLE: begin
                hold_data <= i_word.data;
                err_acc   <= err_acc | i_word.err;
                out_bad   <= 1'b1;
            end
            DATA: begin
                out_data <= hold_data;
                if (tail_q) begin
                    out_keep <= tail_keep;
                    out_bad  <= err_acc;
                end else if (i_word.valid) begin
                    hold_data <= i_word.data;
                    err_acc   <= err_acc | i_word.err;
                    out_keep  <= 8'hff;
                    if (i_word.eof) begin
                        fcs_q     <= fcs_next;
                        tail_keep <= {4'h0, i_word.keep[7:4]};
                        out_bad   <= err_acc | i_word.err;
                        if (!i_word.keep[4])
                            out_keep <= {i_word.keep[3:0], 4'hf};
                    end
                end
            end
            default: out_bad <= 1'b1;
        endcase
    end

    // Dropped frames end with eof and err but no valid beat
    assign o_word.valid = out_valid;
    assign o_word.data  = out_data;
    assign o_word.keep  = out_valid ? out_keep : 8'h00;
    assign o_word.sof   = out_sof;
    assign o_word.eof   = out_eof;
    assign o_word.err   = out_eof && (out_bad || (~i_crc != fcs_q));

    // First payload beat of the frame has gone out
    always_ff @(posedge i_clk) begin
        if (i_reset)
            sof_seen <= 1'b0;
        else if (o_word.eof)
            sof_seen <= 1'b0;
        else if (o_word.valid && o_word.sof)
            sof_seen <= 1'b1;
    end

    // Decode keep must stay contiguous for the CRC fold
    a_crc_en_contig: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_crc_byte_en & (o_crc_byte_en + 8'd1)) == 8'd0
    );

    a_eof_in_frame: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_word.valid && o_word.eof) |-> (sof_seen || o_word.sof)
    );

endmodule

`default_nettype wire

/* crc32_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rx_mac_macros.svh"

module crc32_engine (
    input  wire         i_clk,
    input  wire         i_reset,
    input  wire         i_clear,
    input  wire  [63:0] i_data,
    input  wire  [7:0]  i_byte_en,
    output logic [31:0] o_crc
);

    logic [31:0] crc_next;

    // One byte through the reflected CRC, LSB first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int b = 0; b < 8; b++) begin
            if (c[0])
                c = (c >> 1) ^ `RX_CRC_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    // Lowest lane first, enables are contiguous
    always_comb begin
        crc_next = o_crc;
        for (int i = 0; i < 8; i++) begin
            if (i_byte_en[i])
                crc_next = crc_byte(crc_next, i_data[i*8 +: 8]);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_clear)
            o_crc <= `RX_CRC_INIT;
        else
            o_crc <= crc_next;
    end

endmodule

`default_nettype wire

/* xgmii_rx_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rx_mac_macros.svh"

module xgmii_rx_decode
    import rx_mac_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_reset,
    input  wire  [63:0] i_xgmii_rxd,
    input  wire  [7:0]  i_xgmii_rxc,
    rx_word_if.source   o_word
);

    logic [63:0]    rxd_q;
    logic [7:0]     rxc_q;
    logic           in_frame;
    rx_start_lane_t lane_q;
    rx_start_lane_t lane;

    logic           start0_q;
    logic           start4_q;
    logic           sof;
    logic           valid;
    logic           eof;
    logic           next_term0;
    logic           keep_run;

    logic [63:0]    al_data;
    logic [7:0]     al_ctrl;
    logic [7:0]     in_start;
    logic [7:0]     in_term;
    logic [7:0]     term_vec;
    logic [7:0]     err_vec;
    logic [7:0]     keep;

    // Input word register, idles out of reset
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rxd_q <= {8{`RX_IDLE_CHAR}};
            rxc_q <= 8'hff;
        end else begin
            rxd_q <= i_xgmii_rxd;
            rxc_q <= i_xgmii_rxc;
        end
    end

    assign start0_q = rxc_q[0] && (rxd_q[7:0] == `RX_START_CHAR);
    assign start4_q = rxc_q[4] && (rxd_q[39:32] == `RX_START_CHAR);
    assign sof      = !in_frame && (start0_q || start4_q);
    assign lane     = sof ? (start0_q ? LANE0 : LANE4) : lane_q;

    // Lane-4 start: upper half of the held word below the lower half of the live one
    assign al_data = (lane == LANE0) ? rxd_q : {i_xgmii_rxd[31:0], rxd_q[63:32]};
    assign al_ctrl = (lane == LANE0) ? rxc_q : {i_xgmii_rxc[3:0], rxc_q[7:4]};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            in_start[i] = i_xgmii_rxc[i] && (i_xgmii_rxd[i*8 +: 8] == `RX_START_CHAR);
            in_term[i]  = i_xgmii_rxc[i] && (i_xgmii_rxd[i*8 +: 8] == `RX_TERM_CHAR);
            term_vec[i] = al_ctrl[i] && (al_data[i*8 +: 8] == `RX_TERM_CHAR);
            err_vec[i]  = al_ctrl[i] && (al_data[i*8 +: 8] == `RX_ERROR_CHAR);
        end
    end

    // Bytes up to the first terminate
    always_comb begin
        keep_run = 1'b1;
        for (int i = 0; i < 8; i++) begin
            if (term_vec[i])
                keep_run = 1'b0;
            keep[i] = keep_run;
        end
    end

    // Terminate landing in lane 0 of the next aligned word ends this one
    assign next_term0 = (lane == LANE0) ? in_term[0] : in_term[4];

    assign valid = in_frame || sof;
    assign eof   = valid && ((|term_vec) || next_term0);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            in_frame <= 1'b0;
            lane_q   <= LANE0;
        end else begin
            lane_q <= lane;
            if (eof)
                in_frame <= 1'b0;
            else if (sof)
                in_frame <= 1'b1;
        end
    end

    assign o_word.valid = valid;
    assign o_word.data  = al_data;
    assign o_word.keep  = valid ? keep : 8'h00;
    assign o_word.sof   = sof;
    assign o_word.eof   = eof;
    assign o_word.err   = valid && (|(err_vec & keep));

    // Link guarantees an idle gap, so no word both starts and ends a frame
    a_no_start_with_term: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !((|in_start) && (|in_term))
    );

endmodule

`default_nettype wire

/* rx_word_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rx_word_if;

    logic        valid;
    logic [63:0] data;
    logic [7:0]  keep;
    logic        sof;
    logic        eof;
    logic        err;

    modport source (
        output valid, data, keep, sof, eof, err
    );

    modport sink (
        input valid, data, keep, sof, eof, err
    );

endinterface

`default_nettype wire

/* rx_mac_pkg.sv */
`default_nettype none

package rx_mac_pkg;

    // Frame FSM states
    typedef enum logic [1:0] {IDLE, PREAMBLE, DATA, DROP} rx_state_t;

    // Lane that held the start character
    typedef enum logic {LANE0, LANE4} rx_start_lane_t;

endpackage

`default_nettype wire

/* rx_mac_macros.svh */
`ifndef RX_MAC_MACROS_SVH
`define RX_MAC_MACROS_SVH

// XGMII control characters, meaningful only with the lane's control bit set
`define RX_IDLE_CHAR      8'h07
`define RX_START_CHAR     8'hFB
`define RX_TERM_CHAR      8'hFD
`define RX_ERROR_CHAR     8'hFE

// Preamble and start-frame delimiter
`define RX_PREAMBLE_BYTE  8'h55
`define RX_SFD_BYTE       8'hD5

// CRC-32 in reflected form
`define RX_CRC_POLY       32'hEDB88320
`define RX_CRC_INIT       32'hFFFFFFFF

`endif
